/* hdl/cacheGeomPkg.sv */
package cacheGeomPkg;

  // address split: tag | index | offset
  localparam int AddrWidth    = 32;
  localparam int OffsetWidth  = 5;
  localparam int IndexWidth   = 6;
  localparam int TagWidth     = 21;
  localparam int NumSets      = 64;
  localparam int NumWays      = 2;
  localparam int WordsPerLine = 4;

  typedef logic [AddrWidth-1:0]  addrT;
  typedef logic [TagWidth-1:0]   tagT;
  typedef logic [IndexWidth-1:0] indexT;

  // pipeline word and its byte enables
  typedef logic [63:0] wordT;
  typedef logic [7:0]  maskT;

  typedef logic [WordsPerLine*64-1:0] lineT;
  typedef logic [NumWays-1:0]         wayVecT;

endpackage

/* hdl/memBusPkg.sv */
package memBusPkg;

  localparam int BeatsPerBurst = 4;

  typedef logic [1:0] beatCntT;

  // cache controller states
  typedef enum logic [2:0] {
    idle, compare, writeBack, refillReq, refillData, install
  } ctrlStateT;

endpackage

/* hdl/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 we_i,
  input  cacheGeomPkg::addrT   addr_i,
  input  cacheGeomPkg::wordT   wrData_i,
  input  cacheGeomPkg::maskT   wrMask_i,
  input  cacheGeomPkg::wayVecT wayHit_i,
  input  cacheGeomPkg::wayVecT wayValid_i,
  input  logic                 victimDirty_i,
  input  logic                 lineDone_i,
  input  logic                 memRdReady_i,
  input  logic                 memWrReady_i,
  output logic                 ready_o,
  output logic                 dataOk_o,
  output cacheGeomPkg::indexT  reqIndex_o,
  output cacheGeomPkg::tagT    reqTag_o,
  output logic [1:0]           reqWord_o,
  output cacheGeomPkg::wordT   storeData_o,
  output cacheGeomPkg::maskT   storeMask_o,
  output cacheGeomPkg::wayVecT storeWe_o,
  output cacheGeomPkg::wayVecT installWe_o,
  output cacheGeomPkg::wayVecT victimWay_o,
  output logic                 refillEn_o,
  output logic                 memRdValid_o,
  output cacheGeomPkg::addrT   memRdAddr_o,
  output logic                 memWrValid_o
);

  memBusPkg::ctrlStateT state;
  memBusPkg::ctrlStateT nextState;

  logic                             reqWe;
  cacheGeomPkg::indexT              reqIndex;
  cacheGeomPkg::tagT                reqTag;
  logic [1:0]                       reqWord;
  cacheGeomPkg::wordT               reqData;
  cacheGeomPkg::maskT               reqMask;
  logic [cacheGeomPkg::NumSets-1:0] victimPtr;
  cacheGeomPkg::wayVecT             victimWay;
  logic                             anyHit;
  logic                             accept;

  assign anyHit = |wayHit_i;
  assign ready_o = (state == memBusPkg::idle) ||
                   ((state == memBusPkg::compare) && anyHit);
  assign accept = req_i && ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= memBusPkg::idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      memBusPkg::idle: begin
        if (req_i) begin
          nextState = memBusPkg::compare;
        end
      end
      memBusPkg::compare: begin
        if (anyHit) begin
          nextState = req_i ? memBusPkg::compare : memBusPkg::idle;
        end else if (victimDirty_i) begin
          nextState = memBusPkg::writeBack;
        end else begin
          nextState = memBusPkg::refillReq;
        end
      end
      memBusPkg::writeBack: begin
        if (memWrReady_i) begin
          nextState = memBusPkg::refillReq;
        end
      end
      memBusPkg::refillReq: begin
        if (memRdReady_i) begin
          nextState = memBusPkg::refillData;
        end
      end
      memBusPkg::refillData: begin
        if (lineDone_i) begin
          nextState = memBusPkg::install;
        end
      end
      // line written this cycle, retry the lookup
      memBusPkg::install: begin
        nextState = memBusPkg::compare;
      end
      default: begin
        nextState = memBusPkg::idle;
      end
    endcase
  end

  // request address and kind
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWe    <= 1'b0;
      reqIndex <= '0;
      reqTag   <= '0;
      reqWord  <= '0;
    end else if (accept) begin
      reqWe    <= we_i;
      reqIndex <= addr_i[cacheGeomPkg::OffsetWidth +: cacheGeomPkg::IndexWidth];
      reqTag   <= addr_i[cacheGeomPkg::AddrWidth-1 -: cacheGeomPkg::TagWidth];
      reqWord  <= addr_i[cacheGeomPkg::OffsetWidth-1:3];
    end
  end

  // store payload
  always_ff @(posedge clk) begin
    if (accept) begin
      reqData <= wrData_i;
      reqMask <= wrMask_i;
    end
  end

  // empty way first, else the set's toggle pointer
  always_comb begin
    if (!wayValid_i[0]) begin
      victimWay = 2'b01;
    end else if (!wayValid_i[1]) begin
      victimWay = 2'b10;
    end else begin
      victimWay = victimPtr[reqIndex] ? 2'b10 : 2'b01;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimPtr <= '0;
    end else if (state == memBusPkg::install) begin
      victimPtr[reqIndex] <= ~victimPtr[reqIndex];
    end
  end

  assign dataOk_o    = (state == memBusPkg::compare) && anyHit;
  assign storeWe_o   = ((state == memBusPkg::compare) && reqWe) ? wayHit_i : '0;
  assign installWe_o = (state == memBusPkg::install) ? victimWay : '0;
  assign victimWay_o = victimWay;
  assign refillEn_o  = (state == memBusPkg::refillData);

  assign memRdValid_o = (state == memBusPkg::refillReq);
  assign memWrValid_o = (state == memBusPkg::writeBack);
  assign memRdAddr_o  = {reqTag, reqIndex, {cacheGeomPkg::OffsetWidth{1'b0}}};

  assign reqIndex_o  = reqIndex;
  assign reqTag_o    = reqTag;
  assign reqWord_o   = reqWord;
  assign storeData_o = reqData;
  assign storeMask_o = reqMask;

endmodule

/* hdl/refillBuffer.sv */
`timescale 1ns/1ps

module refillBuffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               refillEn_i,
  input  cacheGeomPkg::wordT memRdData_i,
  input  logic               memRdDataValid_i,
  input  logic               memRdLast_i,
  output cacheGeomPkg::lineT line_o,
  output logic               lineDone_o
);

  localparam int BeatBits = $bits(cacheGeomPkg::lineT) / memBusPkg::BeatsPerBurst;

  memBusPkg::beatCntT beatCnt;
  logic               beatEn;

  assign beatEn = refillEn_i && memRdDataValid_i;

  // beat counter wraps back to slot 0 after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt    <= '0;
      lineDone_o <= 1'b0;
    end else begin
      lineDone_o <= beatEn && memRdLast_i;
      if (beatEn) begin
        beatCnt <= memRdLast_i ? '0 : beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beatEn) begin
      line_o[beatCnt*BeatBits +: BeatBits] <= memRdData_i;
    end
  end

endmodule

/* hdl/cacheWay.sv */
`timescale 1ns/1ps

module cacheWay (
  input  logic                clk,
  input  logic                rst_n,
  input  cacheGeomPkg::indexT index_i,
  input  cacheGeomPkg::tagT   tag_i,
  input  logic [1:0]          word_i,
  input  logic                storeWe_i,
  input  cacheGeomPkg::wordT  storeData_i,
  input  cacheGeomPkg::maskT  storeMask_i,
  input  logic                installWe_i,
  input  cacheGeomPkg::lineT  installLine_i,
  output logic                hit_o,
  output logic                valid_o,
  output logic                dirty_o,
  output cacheGeomPkg::lineT  line_o,
  output cacheGeomPkg::tagT   tag_o
);

  localparam int WordBits = $bits(cacheGeomPkg::wordT);

  cacheGeomPkg::tagT                tagArr  [cacheGeomPkg::NumSets];
  cacheGeomPkg::lineT               dataArr [cacheGeomPkg::NumSets];
  logic [cacheGeomPkg::NumSets-1:0] validArr;
  logic [cacheGeomPkg::NumSets-1:0] dirtyArr;
  cacheGeomPkg::lineT               storeLine;

  // current line with the masked bytes of the store merged in
  always_comb begin
    storeLine = dataArr[index_i];
    for (int w = 0; w < cacheGeomPkg::WordsPerLine; w++) begin
      if (w == int'(word_i)) begin
        for (int b = 0; b < $bits(cacheGeomPkg::maskT); b++) begin
          if (storeMask_i[b]) begin
            storeLine[w*WordBits + b*8 +: 8] = storeData_i[b*8 +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (installWe_i) begin
      tagArr[index_i]  <= tag_i;
      dataArr[index_i] <= installLine_i;
    end else if (storeWe_i) begin
      dataArr[index_i] <= storeLine;
    end
  end

  // install leaves the line clean, a store marks it dirty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (installWe_i) begin
      validArr[index_i] <= 1'b1;
      dirtyArr[index_i] <= 1'b0;
    end else if (storeWe_i) begin
      dirtyArr[index_i] <= 1'b1;
    end
  end

  assign valid_o = validArr[index_i];
  assign dirty_o = dirtyArr[index_i];
  assign tag_o   = tagArr[index_i];
  assign line_o  = dataArr[index_i];
  assign hit_o   = validArr[index_i] && (tagArr[index_i] == tag_i);

endmodule

/* hdl/waySelect.sv */
`timescale 1ns/1ps

module waySelect (
  input  cacheGeomPkg::wayVecT                             wayHit_i,
  input  cacheGeomPkg::wayVecT                             victimWay_i,
  input  cacheGeomPkg::lineT [cacheGeomPkg::NumWays-1:0]   wayLine_i,
  input  cacheGeomPkg::tagT  [cacheGeomPkg::NumWays-1:0]   wayTag_i,
  input  cacheGeomPkg::wayVecT                             wayDirty_i,
  input  logic [1:0]                                       word_i,
  input  cacheGeomPkg::indexT                              index_i,
  output cacheGeomPkg::wordT                               rdData_o,
  output logic                                             victimDirty_o,
  output cacheGeomPkg::addrT                               memWrAddr_o,
  output cacheGeomPkg::lineT                               memWrData_o
);

  localparam int WordBits = $bits(cacheGeomPkg::wordT);

  cacheGeomPkg::lineT victimLine;
  cacheGeomPkg::tagT  victimTag;

  // hit and victim vectors are one-hot or empty
  always_comb begin
    rdData_o   = '0;
    victimLine = '0;
    victimTag  = '0;
    for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
      if (wayHit_i[w]) begin
        rdData_o = wayLine_i[w][word_i*WordBits +: WordBits];
      end
      if (victimWay_i[w]) begin
        victimLine = wayLine_i[w];
        victimTag  = wayTag_i[w];
      end
    end
  end

  assign victimDirty_o = |(victimWay_i & wayDirty_i);

  // write-back goes to the line the victim came from
  assign memWrAddr_o = {victimTag, index_i, {cacheGeomPkg::OffsetWidth{1'b0}}};
  assign memWrData_o = victimLine;

endmodule

/* hdl/dCacheTop.sv */
`timescale 1ns/1ps

module dCacheTop (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_i,
  input  logic               we_i,
  input  cacheGeomPkg::addrT addr_i,
  input  cacheGeomPkg::wordT wrData_i,
  input  cacheGeomPkg::maskT wrMask_i,
  output logic               ready_o,
  output logic               dataOk_o,
  output cacheGeomPkg::wordT rdData_o,
  output logic               memRdValid_o,
  input  logic               memRdReady_i,
  output cacheGeomPkg::addrT memRdAddr_o,
  input  cacheGeomPkg::wordT memRdData_i,
  input  logic               memRdDataValid_i,
  input  logic               memRdLast_i,
  output logic               memWrValid_o,
  input  logic               memWrReady_i,
  output cacheGeomPkg::addrT memWrAddr_o,
  output cacheGeomPkg::lineT memWrData_o
);

  cacheGeomPkg::indexT                            reqIndex;
  cacheGeomPkg::tagT                              reqTag;
  logic [1:0]                                     reqWord;
  cacheGeomPkg::wordT                             storeData;
  cacheGeomPkg::maskT                             storeMask;
  cacheGeomPkg::wayVecT                           storeWe;
  cacheGeomPkg::wayVecT                           installWe;
  cacheGeomPkg::wayVecT                           victimWay;
  cacheGeomPkg::wayVecT                           wayHit;
  cacheGeomPkg::wayVecT                           wayValid;
  cacheGeomPkg::wayVecT                           wayDirty;
  cacheGeomPkg::lineT [cacheGeomPkg::NumWays-1:0] wayLine;
  cacheGeomPkg::tagT  [cacheGeomPkg::NumWays-1:0] wayTag;
  cacheGeomPkg::lineT                             refillLine;
  logic                                           victimDirty;
  logic                                           lineDone;
  logic                                           refillEn;

  cacheCtrl i_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .wayHit_i      (wayHit),
    .wayValid_i    (wayValid),
    .victimDirty_i (victimDirty),
    .lineDone_i    (lineDone),
    .memRdReady_i  (memRdReady_i),
    .memWrReady_i  (memWrReady_i),
    .ready_o       (ready_o),
    .dataOk_o      (dataOk_o),
    .reqIndex_o    (reqIndex),
    .reqTag_o      (reqTag),
    .reqWord_o     (reqWord),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .storeWe_o     (storeWe),
    .installWe_o   (installWe),
    .victimWay_o   (victimWay),
    .refillEn_o    (refillEn),
    .memRdValid_o  (memRdValid_o),
    .memRdAddr_o   (memRdAddr_o),
    .memWrValid_o  (memWrValid_o)
  );

  refillBuffer i_refillBuffer (
    .clk              (clk),
    .rst_n            (rst_n),
    .refillEn_i       (refillEn),
    .memRdData_i      (memRdData_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .line_o           (refillLine),
    .lineDone_o       (lineDone)
  );

  // one storage block per way
  for (genvar w = 0; w < cacheGeomPkg::NumWays; w++) begin : gWay
    cacheWay i_cacheWay (
      .clk           (clk),
      .rst_n         (rst_n),
      .index_i       (reqIndex),
      .tag_i         (reqTag),
      .word_i        (reqWord),
      .storeWe_i     (storeWe[w]),
      .storeData_i   (storeData),
      .storeMask_i   (storeMask),
      .installWe_i   (installWe[w]),
      .installLine_i (refillLine),
      .hit_o         (wayHit[w]),
      .valid_o       (wayValid[w]),
      .dirty_o       (wayDirty[w]),
      .line_o        (wayLine[w]),
      .tag_o         (wayTag[w])
    );
  end

  waySelect i_waySelect (
    .wayHit_i      (wayHit),
    .victimWay_i   (victimWay),
    .wayLine_i     (wayLine),
    .wayTag_i      (wayTag),
    .wayDirty_i    (wayDirty),
    .word_i        (reqWord),
    .index_i       (reqIndex),
    .rdData_o      (rdData_o),
    .victimDirty_o (victimDirty),
    .memWrAddr_o   (memWrAddr_o),
    .memWrData_o   (memWrData_o)
  );

endmodule

/* bench/memSlave.sv */
`timescale 1ns/1ps

module memSlave (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               memRdValid_i,
  input  cacheGeomPkg::addrT memRdAddr_i,
  output logic               memRdReady_o,
  output cacheGeomPkg::wordT memRdData_o,
  output logic               memRdDataValid_o,
  output logic               memRdLast_o,
  input  logic               memWrValid_i,
  input  cacheGeomPkg::addrT memWrAddr_i,
  input  cacheGeomPkg::lineT memWrData_i,
  output logic               memWrReady_o
);

  // 32 KB window, word index is addr[14:3]
  localparam int MemWords = 4096;

  cacheGeomPkg::wordT mem [MemWords];
  int                 seed = 32'h1b2d;

  function automatic cacheGeomPkg::wordT patternWord(input cacheGeomPkg::addrT a);
    return {a ^ 32'h5a0f_c3e1, (a * 32'h0001_0003) + 32'h2468_ace1};
  endfunction

  initial begin : serveProc
    int delay;
    int base;
    memRdReady_o     = 1'b0;
    memRdData_o      = '0;
    memRdDataValid_o = 1'b0;
    memRdLast_o      = 1'b0;
    memWrReady_o     = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = patternWord(cacheGeomPkg::addrT'(i * 8));
    end
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && (memWrValid_i || memRdValid_i)) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (memWrValid_i) begin
          base = int'(memWrAddr_i[14:5]) * 4;
          memWrReady_o = 1'b1;
          for (int w = 0; w < 4; w++) begin
            mem[base + w] = memWrData_i[w*64 +: 64];
          end
          @(posedge clk);
          #1;
          memWrReady_o = 1'b0;
        end else begin
          base = int'(memRdAddr_i[14:5]) * 4;
          memRdReady_o = 1'b1;
          @(posedge clk);
          #1;
          memRdReady_o = 1'b0;
          // four beats back to back, last one flagged
          for (int b = 0; b < 4; b++) begin
            memRdDataValid_o = 1'b1;
            memRdData_o      = mem[base + b];
            memRdLast_o      = (b == 3);
            @(posedge clk);
            #1;
          end
          memRdDataValid_o = 1'b0;
          memRdLast_o      = 1'b0;
        end
      end
    end
  end

endmodule

/* bench/dCacheSva.sv */
`timescale 1ns/1ps

module dCacheSva (
  input logic clk,
  input logic rst_n,
  input logic ready_i,
  input logic dataOk_i,
  input logic memRdValid_i,
  input logic memRdReady_i,
  input logic memWrValid_i,
  input logic memWrReady_i
);

  // requests stay up until the memory takes them
  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_i && !memRdReady_i |=> memRdValid_i)
    else $error("memRdValid_o dropped before memRdReady_i");

  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_i && !memWrReady_i |=> memWrValid_i)
    else $error("memWrValid_o dropped before memWrReady_i");

  rdWrExcl: assert property (@(posedge clk) disable iff (!rst_n)
    !(memRdValid_i && memWrValid_i))
    else $error("memory read and write requested together");

  okNeedsReady: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i |-> ready_i)
    else $error("dataOk_o high while ready_o low");

endmodule

bind cacheCtrl dCacheSva i_dCacheSva (
  .clk          (clk),
  .rst_n        (rst_n),
  .ready_i      (ready_o),
  .dataOk_i     (dataOk_o),
  .memRdValid_i (memRdValid_o),
  .memRdReady_i (memRdReady_i),
  .memWrValid_i (memWrValid_o),
  .memWrReady_i (memWrReady_i)
);

/* bench/dCacheTb.sv */
`timescale 1ns/1ps

module dCacheTb;

  localparam int NumOps   = 317;
  localparam int MemWords = 4096;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               req_i;
  logic               we_i;
  cacheGeomPkg::addrT addr_i;
  cacheGeomPkg::wordT wrData_i;
  cacheGeomPkg::maskT wrMask_i;
  logic               ready_o;
  logic               dataOk_o;
  cacheGeomPkg::wordT rdData_o;
  logic               memRdValid_o;
  logic               memRdReady_i;
  cacheGeomPkg::addrT memRdAddr_o;
  cacheGeomPkg::wordT memRdData_i;
  logic               memRdDataValid_i;
  logic               memRdLast_i;
  logic               memWrValid_o;
  logic               memWrReady_i;
  cacheGeomPkg::addrT memWrAddr_o;
  cacheGeomPkg::lineT memWrData_o;

  int                 seed = 32'h1b2d;
  int                 errCount = 0;
  int                 checkCount = 0;
  int                 cycle = 0;
  int                 refillCount = 0;
  int                 wbMatch = 0;
  string              testName = "reset";
  cacheGeomPkg::addrT wbAddr = '1;
  cacheGeomPkg::wordT shadow [MemWords];

  // accepted requests still waiting for dataOk_o
  logic               qWe [$];
  cacheGeomPkg::addrT qAddr [$];
  cacheGeomPkg::wordT qData [$];
  cacheGeomPkg::maskT qMask [$];
  logic               qHit [$];
  int                 qCyc [$];

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  dCacheTop i_dCacheTop (.*);

  memSlave i_memSlave (
    .clk              (clk),
    .rst_n            (rst_n),
    .memRdValid_i     (memRdValid_o),
    .memRdAddr_i      (memRdAddr_o),
    .memRdReady_o     (memRdReady_i),
    .memRdData_o      (memRdData_i),
    .memRdDataValid_o (memRdDataValid_i),
    .memRdLast_o      (memRdLast_i),
    .memWrValid_i     (memWrValid_o),
    .memWrAddr_i      (memWrAddr_o),
    .memWrData_i      (memWrData_o),
    .memWrReady_o     (memWrReady_i)
  );

  // same fill rule as the memory model
  function automatic cacheGeomPkg::wordT patternWord(input cacheGeomPkg::addrT a);
    return {a ^ 32'h5a0f_c3e1, (a * 32'h0001_0003) + 32'h2468_ace1};
  endfunction

  function automatic cacheGeomPkg::addrT mkAddr(input int tag, input int index, input int word);
    return cacheGeomPkg::addrT'((tag << 11) | (index << 5) | (word << 3));
  endfunction

  function automatic cacheGeomPkg::wordT refLoad(input cacheGeomPkg::addrT a);
    return shadow[a[14:3]];
  endfunction

  function automatic cacheGeomPkg::lineT shadowLine(input cacheGeomPkg::addrT a);
    cacheGeomPkg::lineT line;
    for (int w = 0; w < 4; w++) begin
      line[w*64 +: 64] = shadow[int'(a[14:5]) * 4 + w];
    end
    return line;
  endfunction

  task automatic applyStore(input cacheGeomPkg::addrT a, input cacheGeomPkg::wordT d,
                            input cacheGeomPkg::maskT m);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        shadow[a[14:3]][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  task automatic checkVal(input string what, input logic [255:0] exp, input logic [255:0] act);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      $display("FAIL %s %s: expected %0h actual %0h", testName, what, exp, act);
    end
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic issue(input logic we, input cacheGeomPkg::addrT a, input cacheGeomPkg::wordT d,
                       input cacheGeomPkg::maskT m, input logic hit);
    req_i    = 1'b1;
    we_i     = we;
    addr_i   = a;
    wrData_i = d;
    wrMask_i = m;
    @(negedge clk);
    while (!ready_o) begin
      @(negedge clk);
    end
    qWe.push_back(we);
    qAddr.push_back(a);
    qData.push_back(d);
    qMask.push_back(m);
    qHit.push_back(hit);
    qCyc.push_back(cycle);
    @(posedge clk);
    #1;
    req_i = 1'b0;
  endtask

  task automatic drain();
    while (qAddr.size() != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  always @(negedge clk) begin : compareProc
    cacheGeomPkg::addrT a;
    cacheGeomPkg::wordT d;
    cacheGeomPkg::maskT m;
    logic               we;
    logic               hit;
    int                 cyc;
    if (rst_n && dataOk_o) begin
      if (qAddr.size() == 0) begin
        errCount++;
        $display("dataOk_o pulsed with no request outstanding");
      end else begin
        a   = qAddr.pop_front();
        d   = qData.pop_front();
        m   = qMask.pop_front();
        we  = qWe.pop_front();
        hit = qHit.pop_front();
        cyc = qCyc.pop_front();
        if (hit) begin
          checkVal("hit latency", 1, cycle - cyc);
        end
        if (we) begin
          applyStore(a, d, m);
        end else begin
          checkVal("load data", refLoad(a), rdData_o);
        end
      end
    end
  end

  // memory traffic seen by the cache
  always @(negedge clk) begin
    if (rst_n && memRdValid_o && memRdReady_i) begin
      refillCount++;
      // the refill fetches the line of the request that missed
      if (qAddr.size() == 0) begin
        errCount++;
        $display("refill requested with no request outstanding");
      end else begin
        checkVal("refill address", qAddr[0] & 32'hffff_ffe0, memRdAddr_o);
      end
    end
    if (rst_n && memWrValid_o && memWrReady_i) begin
      if (memWrAddr_o == wbAddr) begin
        wbMatch++;
      end
      checkVal("write-back line", shadowLine(memWrAddr_o), memWrData_o);
    end
  end

  initial begin
    logic               rndWe;
    cacheGeomPkg::addrT rndAddr;
    req_i    = 1'b0;
    we_i     = 1'b0;
    addr_i   = '0;
    wrData_i = '0;
    wrMask_i = '0;
    rst_n    = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      shadow[i] = patternWord(cacheGeomPkg::addrT'(i * 8));
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    checkVal("ready_o", 1, ready_o);
    checkVal("dataOk_o", 0, dataOk_o);
    checkVal("memRdValid_o", 0, memRdValid_o);
    checkVal("memWrValid_o", 0, memWrValid_o);
    @(posedge clk);
    #1;

    testName = "loadMiss";
    issue(1'b0, mkAddr(1, 3, 1), '0, '0, 1'b0);
    drain();
    checkVal("refill count", 1, refillCount);
    issue(1'b0, mkAddr(1, 3, 3), '0, '0, 1'b1);
    drain();
    checkVal("refill count", 1, refillCount);

    testName = "hitStream";
    for (int w = 0; w < 4; w++) begin
      issue(1'b0, mkAddr(1, 3, 3 - w), '0, '0, 1'b1);
    end
    drain();

    testName = "byteMask";
    issue(1'b1, mkAddr(1, 4, 2), 64'h1111_2222_3333_4444, 8'h0f, 1'b0);
    issue(1'b1, mkAddr(1, 4, 2), 64'haaaa_bbbb_cccc_dddd, 8'hf0, 1'b1);
    issue(1'b1, mkAddr(1, 4, 2), 64'h0123_4567_89ab_cdef, 8'h81, 1'b1);
    issue(1'b1, mkAddr(1, 4, 0), 64'hfeed_face_cafe_f00d, 8'h3c, 1'b1);
    issue(1'b0, mkAddr(1, 4, 2), '0, '0, 1'b1);
    issue(1'b0, mkAddr(1, 4, 0), '0, '0, 1'b1);
    issue(1'b0, mkAddr(1, 4, 1), '0, '0, 1'b1);
    drain();

    // three tags on a fresh set, the dirty one must leave
    testName = "eviction";
    wbAddr   = mkAddr(1, 20, 0);
    issue(1'b1, mkAddr(1, 20, 1), 64'h5555_6666_7777_8888, 8'hff, 1'b0);
    issue(1'b0, mkAddr(2, 20, 0), '0, '0, 1'b0);
    issue(1'b0, mkAddr(3, 20, 2), '0, '0, 1'b0);
    drain();
    checkVal("dirty line write-backs", 1, wbMatch);
    issue(1'b0, mkAddr(1, 20, 1), '0, '0, 1'b0);
    drain();

    testName = "randomMix";
    for (int i = 0; i < 300; i++) begin
      rndWe   = $random(seed) & 1;
      rndAddr = mkAddr(4 + ($random(seed) & 3), 8 + ($random(seed) & 3), $random(seed) & 3);
      issue(rndWe, rndAddr, {$random(seed), $random(seed)}, $random(seed), 1'b0);
    end
    drain();

    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (NumOps * 40) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", NumOps * 40);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* project.f */
hdl/cacheGeomPkg.sv
hdl/memBusPkg.sv
hdl/cacheCtrl.sv
hdl/refillBuffer.sv
hdl/cacheWay.sv
hdl/waySelect.sv
hdl/dCacheTop.sv
bench/memSlave.sv
bench/dCacheSva.sv
bench/dCacheTb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - hdl/cacheGeomPkg.sv
      - hdl/memBusPkg.sv
      - hdl/cacheCtrl.sv
      - hdl/refillBuffer.sv
      - hdl/cacheWay.sv
      - hdl/waySelect.sv
      - hdl/dCacheTop.sv
  - target: test
    files:
      - bench/memSlave.sv
      - bench/dCacheSva.sv
      - bench/dCacheTb.sv
